// ==== dram_ctrl_top.f ====
common/dram_pack.sv
common/dram_command_if.sv
dram_command/dram_command.sv
hdl/request_queue.sv
hdl/dram_ctrl_top.sv
testbench/dram_ctrl_assert.sv
testbench/dram_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dram_ctrl_tb \
    -f dram_ctrl_top.f -o dram_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dram_ctrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1

// ==== testbench/dram_ctrl_tb.sv ====
`timescale 1ns/1ps

module dram_ctrl_tb;

    localparam int DEPTH = 4;
    localparam int T_PWUP = 8, T_PD = 4, T_DLLK = 6, T_MOD = 3, T_ZQINIT = 5;
    localparam int T_RCD = 3, T_CAS = 4, T_CWD = 3, T_BURST = 4, T_WR = 3, T_RP = 3;
    localparam int RD_LEN = T_CAS + T_BURST;
    localparam int WR_LEN = T_CWD + T_BURST + T_WR;

    logic CLK, nRST, req_valid, req_write, refresh, req_full, done;
    logic cke, reset_n, cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14, init_done;
    dram_pack::host_addr_t req_addr;
    dram_pack::bg_t        bg;
    dram_pack::ba_t        ba;
    logic [13:0]           addr;

    // Decoded command log
    logic [4:0] log_kind [$];
    int         log_bg [$];
    int         log_ba [$];
    int         log_val [$];
    int         log_cyc [$];
    int cycle = 0;
    int done_cnt = 0;
    int init_cyc = -1;
    int errors = 0;
    int checks = 0;

    dram_ctrl_top #(
        .DEPTH(DEPTH), .T_PWUP(T_PWUP), .T_PD(T_PD), .T_DLLK(T_DLLK), .T_MOD(T_MOD),
        .T_ZQINIT(T_ZQINIT), .T_RCD(T_RCD), .T_CAS(T_CAS), .T_CWD(T_CWD),
        .T_BURST(T_BURST), .T_WR(T_WR), .T_RP(T_RP)
    ) u_dram_ctrl_top (.*);

    bind dram_ctrl_top dram_ctrl_assert u_dram_ctrl_assert (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) cycle <= cycle + 1;

    always @(negedge CLK) begin
        logic [4:0] code;
        code = {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14};
        if (done)
            done_cnt++;
        if (init_done && init_cyc < 0)
            init_cyc = cycle;
        if (!cs_n && code != dram_pack::NOP_CMD) begin
            log_kind.push_back(act_n ? code : dram_pack::ACTIVATE_CMD);
            log_bg.push_back(int'(bg));
            log_ba.push_back(int'(ba));
            if (!act_n)
                log_val.push_back(int'({ras_n_a16, cas_n_a15, we_n_a14, addr})); // Full row
            else if (code == dram_pack::READ_CMD || code == dram_pack::WRITE_CMD)
                log_val.push_back(int'(addr[9:0]));
            else
                log_val.push_back(int'(addr));
            log_cyc.push_back(cycle);
        end
    end

    task automatic post(input logic wr, input dram_pack::host_addr_t a);
        @(posedge CLK);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= a;
        @(posedge CLK);
        req_valid <= 1'b0;
    endtask

    task automatic wait_log(input string name, input int n_cmd, input int n_done);
        int t;
        t = 0;
        while ((log_kind.size() < n_cmd || done_cnt < n_done) && t < 400) begin
            @(posedge CLK);
            t++;
        end
        if (t >= 400) begin
            errors++;
            $display("%s: timed out waiting for %0d commands and %0d done pulses",
                     name, n_cmd, n_done);
        end
    endtask

    task automatic check_val(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("[FAIL] %s: expected %0d, got %0d", name, exp, act);
        end
    endtask

    // gap is the cycle distance from the previous logged command, 0 skips it
    task automatic check_cmd(input string name, input int idx, input logic [4:0] kind,
                             input int bgv, input int bav, input int val, input int gap);
        checks++;
        if (idx >= log_kind.size()) begin
            errors++;
            $display("%s: command %0d never appeared on the pins", name, idx);
        end else begin
            if (log_kind[idx] != kind || log_bg[idx] != bgv || log_ba[idx] != bav
                || log_val[idx] != val) begin
                errors++;
                $display("[FAIL] %s cmd %0d: expected %b/%0d/%0d/%h, got %b/%0d/%0d/%h",
                         name, idx, kind, bgv, bav, val,
                         log_kind[idx], log_bg[idx], log_ba[idx], log_val[idx]);
            end
            if (gap > 0 && idx > 0)
                check_val({name, " gap"}, gap, log_cyc[idx] - log_cyc[idx-1]);
        end
    endtask

    task automatic test_init();
        int t;
        t = 0;
        @(negedge CLK);
        check_val("reset cke", 0, int'(cke));
        check_val("reset reset_n", 0, int'(reset_n));
        check_val("reset init_done", 0, int'(init_done));
        check_val("reset done", 0, int'(done));
        check_val("reset req_full", 0, int'(req_full));
        check_val("reset pins", int'(dram_pack::POWER_UP_PRG),
                  int'({cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14}));
        while (!init_done && t < 500) begin
            @(posedge CLK);
            t++;
        end
        if (!init_done) begin
            errors++;
            $display("init: init_done never rose");
        end
        @(negedge CLK);
        check_val("init cke", 1, int'(cke));
        check_val("init reset_n", 1, int'(reset_n));
        for (int i = 0; i < 7; i++)
            check_cmd("init", i, dram_pack::LOAD_MODE_CMD, int'(dram_pack::INIT_TABLE[i][17:16]),
                      int'(dram_pack::INIT_TABLE[i][15:14]), int'(dram_pack::INIT_TABLE[i][13:0]),
                      (i == 0) ? 0 : ((i == 1) ? T_DLLK : T_MOD));
        check_cmd("init", 7, dram_pack::ZQ_CMD, 0, 0, 'h400, T_MOD);
        if (log_cyc.size() > 7)
            check_val("init done cycle", log_cyc[7] + T_ZQINIT, init_cyc);
    endtask

    // Expects ACTIVATE, then the given accesses, then PRECHARGE
    task automatic run_access(input string name, input dram_pack::host_addr_t a,
                              input logic wr);
        int b;
        int d;
        b = log_kind.size();
        d = done_cnt;
        post(wr, a);
        wait_log(name, b + 3, d + 1);
        check_cmd(name, b, dram_pack::ACTIVATE_CMD, a[13:12], a[11:10], a[26:14], 0);
        check_cmd(name, b + 1, wr ? dram_pack::WRITE_CMD : dram_pack::READ_CMD,
                  a[13:12], a[11:10], a[9:0], T_RCD);
        check_cmd(name, b + 2, dram_pack::PRECHARGE_CMD, a[13:12], a[11:10], 0,
                  wr ? WR_LEN : RD_LEN);
        check_val({name, " done count"}, d + 1, done_cnt);
    endtask

    task automatic test_row_hit();
        int b;
        int d;
        dram_pack::host_addr_t a1, a2;
        b = log_kind.size();
        d = done_cnt;
        a1 = dram_pack::host_addr_t'($urandom);
        a2 = {a1[26:10], 10'($urandom)};
        post(1'b0, a1);
        post(1'b0, a2);
        wait_log("row hit", b + 4, d + 2);
        check_cmd("row hit", b, dram_pack::ACTIVATE_CMD, a1[13:12], a1[11:10], a1[26:14], 0);
        check_cmd("row hit", b + 1, dram_pack::READ_CMD, a1[13:12], a1[11:10], a1[9:0], T_RCD);
        check_cmd("row hit", b + 2, dram_pack::READ_CMD, a2[13:12], a2[11:10], a2[9:0], RD_LEN);
        check_cmd("row hit", b + 3, dram_pack::PRECHARGE_CMD, a1[13:12], a1[11:10], 0, RD_LEN);
        check_val("row hit done count", d + 2, done_cnt);
    endtask

    task automatic test_row_miss();
        int b;
        int d;
        dram_pack::host_addr_t a1, a2;
        b = log_kind.size();
        d = done_cnt;
        a1 = dram_pack::host_addr_t'($urandom);
        a2 = a1 ^ (27'h1 << 14); // Same bank, next row
        post(1'b1, a1);
        post(1'b1, a2);
        wait_log("row miss", b + 6, d + 2);
        check_cmd("row miss", b, dram_pack::ACTIVATE_CMD, a1[13:12], a1[11:10], a1[26:14], 0);
        check_cmd("row miss", b + 1, dram_pack::WRITE_CMD, a1[13:12], a1[11:10], a1[9:0], T_RCD);
        check_cmd("row miss", b + 2, dram_pack::PRECHARGE_CMD, a1[13:12], a1[11:10], 0, WR_LEN);
        check_cmd("row miss", b + 3, dram_pack::ACTIVATE_CMD, a2[13:12], a2[11:10], a2[26:14],
                  T_RP);
        check_cmd("row miss", b + 4, dram_pack::WRITE_CMD, a2[13:12], a2[11:10], a2[9:0], T_RCD);
        check_cmd("row miss", b + 5, dram_pack::PRECHARGE_CMD, a2[13:12], a2[11:10], 0, WR_LEN);
    endtask

    task automatic test_refresh();
        int b;
        int d;
        dram_pack::host_addr_t a;
        b = log_kind.size();
        d = done_cnt;
        a = dram_pack::host_addr_t'($urandom);
        @(posedge CLK);
        refresh <= 1'b1;
        post(1'b0, a);
        repeat (40) @(posedge CLK); // Observation window, nothing may happen
        check_val("refresh commands", b, log_kind.size());
        check_val("refresh done count", d, done_cnt);
        @(posedge CLK);
        refresh <= 1'b0;
        wait_log("refresh", b + 3, d + 1);
        check_cmd("refresh", b, dram_pack::ACTIVATE_CMD, a[13:12], a[11:10], a[26:14], 0);
        check_cmd("refresh", b + 1, dram_pack::READ_CMD, a[13:12], a[11:10], a[9:0], T_RCD);
        check_cmd("refresh", b + 2, dram_pack::PRECHARGE_CMD, a[13:12], a[11:10], 0, RD_LEN);
    endtask

    task automatic test_backpressure();
        int d;
        d = done_cnt;
        @(posedge CLK);
        refresh <= 1'b1;
        for (int i = 0; i < DEPTH; i++)
            post(1'($urandom), dram_pack::host_addr_t'($urandom));
        @(negedge CLK);
        check_val("backpressure full", 1, int'(req_full));
        post(1'b1, dram_pack::host_addr_t'($urandom)); // Dropped
        @(negedge CLK);
        check_val("backpressure still full", 1, int'(req_full));
        @(posedge CLK);
        refresh <= 1'b0;
        wait_log("backpressure", 0, d + DEPTH);
        repeat (60) @(posedge CLK);
        check_val("backpressure done count", d + DEPTH, done_cnt);
        check_val("backpressure drained", 0, int'(req_full));
    endtask

    initial begin
        int unsigned rnd;
        rnd = $urandom(32'hc7b21815);
        nRST = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        refresh = 1'b0;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        test_init();
        run_access("single write", dram_pack::host_addr_t'($urandom), 1'b1);
        test_row_hit();
        test_row_miss();
        test_refresh();
        test_backpressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== testbench/dram_ctrl_assert.sv ====
`timescale 1ns/1ps

module dram_ctrl_assert (
    input logic CLK,
    input logic nRST,
    input logic cs_n,
    input logic act_n,
    input logic ras_n_a16,
    input logic cas_n_a15,
    input logic we_n_a14,
    input logic refresh,
    input logic done,
    input logic cke,
    input logic init_done
);

    logic cmd_cycle;

    // Chip selected with anything but NOP
    assign cmd_cycle = !cs_n && ({act_n, ras_n_a16, cas_n_a15, we_n_a14} != 4'b1111);

    cmd_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        cmd_cycle |=> !cmd_cycle)
        else $error("command held on the pins for more than one cycle");

    done_single: assert property (@(posedge CLK) disable iff (!nRST) done |=> !done)
        else $error("done high on two consecutive cycles");

    no_act_in_refresh: assert property (@(posedge CLK) disable iff (!nRST)
        (!cs_n && !act_n) |-> !refresh)
        else $error("ACTIVATE issued while refresh is high");

    cke_after_init: assert property (@(posedge CLK) disable iff (!nRST) init_done |-> cke)
        else $error("cke low after init_done");

endmodule

// ==== hdl/dram_ctrl_top.sv ====
`timescale 1ns/1ps

module dram_ctrl_top #(
    parameter int DEPTH    = 4,
    parameter int T_PWUP   = 8,
    parameter int T_PD     = 4,
    parameter int T_DLLK   = 6,
    parameter int T_MOD    = 3,
    parameter int T_ZQINIT = 5,
    parameter int T_RCD    = 3,
    parameter int T_CAS    = 4,
    parameter int T_CWD    = 3,
    parameter int T_BURST  = 4,
    parameter int T_WR     = 3,
    parameter int T_RP     = 3
) (
    input  logic                  CLK,
    input  logic                  nRST,
    // Host side
    input  logic                  req_valid,
    input  logic                  req_write,
    input  dram_pack::host_addr_t req_addr,
    output logic                  req_full,
    input  logic                  refresh,
    output logic                  done,
    // DDR4 command pins
    output logic                  cke,
    output logic                  reset_n,
    output logic                  cs_n,
    output logic                  act_n,
    output logic                  ras_n_a16,
    output logic                  cas_n_a15,
    output logic                  we_n_a14,
    output dram_pack::bg_t        bg,
    output dram_pack::ba_t        ba,
    output logic [13:0]           addr,
    output logic                  init_done
);

    dram_command_if cmd_if ();

    request_queue #(
        .DEPTH (DEPTH)
    ) u_request_queue (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_full  (req_full),
        .sch       (cmd_if.sched)
    );

    dram_command #(
        .T_PWUP   (T_PWUP),
        .T_PD     (T_PD),
        .T_DLLK   (T_DLLK),
        .T_MOD    (T_MOD),
        .T_ZQINIT (T_ZQINIT),
        .T_RCD    (T_RCD),
        .T_CAS    (T_CAS),
        .T_CWD    (T_CWD),
        .T_BURST  (T_BURST),
        .T_WR     (T_WR),
        .T_RP     (T_RP)
    ) u_dram_command (
        .CLK       (CLK),
        .nRST      (nRST),
        .refresh   (refresh),
        .dr_sche   (cmd_if.cmd),
        .cke       (cke),
        .reset_n   (reset_n),
        .cs_n      (cs_n),
        .act_n     (act_n),
        .ras_n_a16 (ras_n_a16),
        .cas_n_a15 (cas_n_a15),
        .we_n_a14  (we_n_a14),
        .bg        (bg),
        .ba        (ba),
        .addr      (addr),
        .done      (done),
        .init_done (init_done)
    );

endmodule

// ==== hdl/request_queue.sv ====
`timescale 1ns/1ps

module request_queue #(
    parameter int DEPTH = 4
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  dram_pack::host_addr_t req_addr,
    output logic                  req_full,
    dram_command_if.sched         sch
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic                  write_mem [DEPTH];
    dram_pack::host_addr_t addr_mem  [DEPTH];

    logic [PTR_W-1:0] head, tail;
    logic [PTR_W-1:0] head_nxt;
    logic [CNT_W-1:0] count;
    logic             push, pop;

    dram_pack::host_addr_t cur_addr, nxt_addr;

    assign req_full = (count == CNT_W'(DEPTH));
    assign push     = req_valid && !req_full; // Strobes while full are dropped
    assign pop      = sch.request_done && (count != '0);

    // Wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign head_nxt = ptr_inc(head);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push)
                tail <= ptr_inc(tail);
            if (pop)
                head <= head_nxt;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            write_mem[tail] <= req_write;
            addr_mem[tail]  <= req_addr;
        end
    end

    assign cur_addr = addr_mem[head];
    assign nxt_addr = addr_mem[head_nxt];

    // Head entry
    assign sch.cur_valid = (count != '0);
    assign sch.cur_write = write_mem[head];
    assign sch.cur_col   = cur_addr[dram_pack::BA_LSB-1:0];
    assign sch.cur_ba    = cur_addr[dram_pack::BG_LSB-1:dram_pack::BA_LSB];
    assign sch.cur_bg    = cur_addr[dram_pack::ROW_LSB-1:dram_pack::BG_LSB];
    assign sch.cur_row   = dram_pack::row_t'(cur_addr[26:dram_pack::ROW_LSB]);

    // Follow-through entry
    assign sch.nxt_valid = (count > CNT_W'(1));
    assign sch.nxt_write = write_mem[head_nxt];
    assign sch.nxt_ba    = nxt_addr[dram_pack::BG_LSB-1:dram_pack::BA_LSB];
    assign sch.nxt_bg    = nxt_addr[dram_pack::ROW_LSB-1:dram_pack::BG_LSB];
    assign sch.nxt_row   = dram_pack::row_t'(nxt_addr[26:dram_pack::ROW_LSB]);

endmodule

// ==== dram_command/dram_command.sv ====
`timescale 1ns/1ps

module dram_command #(
    parameter int T_PWUP   = 8,
    parameter int T_PD     = 4,
    parameter int T_DLLK   = 6,
    parameter int T_MOD    = 3,
    parameter int T_ZQINIT = 5,
    parameter int T_RCD    = 3,
    parameter int T_CAS    = 4,
    parameter int T_CWD    = 3,
    parameter int T_BURST  = 4,
    parameter int T_WR     = 3,
    parameter int T_RP     = 3
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              refresh,
    dram_command_if.cmd       dr_sche,
    output logic              cke,
    output logic              reset_n,
    output logic              cs_n,
    output logic              act_n,
    output logic              ras_n_a16,
    output logic              cas_n_a15,
    output logic              we_n_a14,
    output dram_pack::bg_t    bg,
    output dram_pack::ba_t    ba,
    output logic [13:0]       addr,
    output logic              done,
    output logic              init_done
);

    dram_pack::dram_state_t state, n_state;
    logic [11:0]            timing_count, n_timing_count;
    logic [11:0]            rollover_value;
    logic                   state_end;
    logic                   first_cycle;
    logic                   row_hit;
    logic [2:0]             load_idx;
    logic [17:0]            load_entry;
    dram_pack::cmd_code_t   cmd;
    dram_pack::bg_t         open_bg;
    dram_pack::ba_t         open_ba;

    assign state_end   = (timing_count == rollover_value);
    assign first_cycle = (timing_count == 12'd1);

    // Next request can reuse the open row
    assign row_hit = !refresh && dr_sche.nxt_valid
                     && (dr_sche.nxt_bg == dr_sche.cur_bg)
                     && (dr_sche.nxt_ba == dr_sche.cur_ba)
                     && (dr_sche.nxt_row == dr_sche.cur_row);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state        <= dram_pack::POWER_UP;
            timing_count <= 12'd1;
            init_done    <= 1'b0;
        end else begin
            state        <= n_state;
            timing_count <= n_timing_count;
            if (state == dram_pack::ZQ_CL && n_state == dram_pack::IDLE)
                init_done <= 1'b1;
        end
    end

    // Bank of the open row, needed once the head has been popped
    always_ff @(posedge CLK) begin
        if (state == dram_pack::ACTIVATE && first_cycle) begin
            open_bg <= dr_sche.cur_bg;
            open_ba <= dr_sche.cur_ba;
        end
    end

    always_comb begin
        rollover_value = 12'hFFF;
        case (state)
            dram_pack::POWER_UP,
            dram_pack::PRE_RESET,
            dram_pack::RESET:         rollover_value = 12'(T_PWUP);
            dram_pack::NOP:           rollover_value = 12'(T_PD);
            dram_pack::LOAD_BG0_REG1: rollover_value = 12'(T_DLLK);
            dram_pack::LOAD_BG0_REG3,
            dram_pack::LOAD_BG1_REG6,
            dram_pack::LOAD_BG1_REG5,
            dram_pack::LOAD_BG1_REG4,
            dram_pack::LOAD_BG0_REG2,
            dram_pack::LOAD_BG0_REG0: rollover_value = 12'(T_MOD);
            dram_pack::ZQ_CL:         rollover_value = 12'(T_ZQINIT);
            dram_pack::ACTIVATE:      rollover_value = 12'(T_RCD);
            dram_pack::READ_COMMAND:  rollover_value = 12'(T_CAS + T_BURST);
            dram_pack::WRITE_COMMAND: rollover_value = 12'(T_CWD + T_BURST + T_WR);
            dram_pack::PRECHARGE:     rollover_value = 12'(T_RP);
            default: ;
        endcase
    end

    always_comb begin
        n_state = state;
        case (state)
            dram_pack::POWER_UP:      if (state_end) n_state = dram_pack::PRE_RESET;
            dram_pack::PRE_RESET:     if (state_end) n_state = dram_pack::RESET;
            dram_pack::RESET:         if (state_end) n_state = dram_pack::NOP;
            dram_pack::NOP:           if (state_end) n_state = dram_pack::LOAD_BG0_REG1;
            dram_pack::LOAD_BG0_REG1: if (state_end) n_state = dram_pack::LOAD_BG0_REG3;
            dram_pack::LOAD_BG0_REG3: if (state_end) n_state = dram_pack::LOAD_BG1_REG6;
            dram_pack::LOAD_BG1_REG6: if (state_end) n_state = dram_pack::LOAD_BG1_REG5;
            dram_pack::LOAD_BG1_REG5: if (state_end) n_state = dram_pack::LOAD_BG1_REG4;
            dram_pack::LOAD_BG1_REG4: if (state_end) n_state = dram_pack::LOAD_BG0_REG2;
            dram_pack::LOAD_BG0_REG2: if (state_end) n_state = dram_pack::LOAD_BG0_REG0;
            dram_pack::LOAD_BG0_REG0: if (state_end) n_state = dram_pack::ZQ_CL;
            dram_pack::ZQ_CL:         if (state_end) n_state = dram_pack::IDLE;
            dram_pack::IDLE: begin
                if (dr_sche.cur_valid && !refresh)
                    n_state = dram_pack::ACTIVATE;
            end
            dram_pack::ACTIVATE: begin
                if (state_end)
                    n_state = dr_sche.cur_write ? dram_pack::WRITE_COMMAND
                                                : dram_pack::READ_COMMAND;
            end
            dram_pack::WRITE_COMMAND,
            dram_pack::READ_COMMAND: begin
                if (state_end && row_hit)
                    n_state = dr_sche.nxt_write ? dram_pack::WRITE_COMMAND
                                                : dram_pack::READ_COMMAND;
                else if (state_end)
                    n_state = dram_pack::PRECHARGE;
            end
            dram_pack::PRECHARGE: begin
                if (state_end)
                    n_state = (dr_sche.cur_valid && !refresh) ? dram_pack::ACTIVATE
                                                              : dram_pack::IDLE;
            end
            default: n_state = dram_pack::POWER_UP;
        endcase

        // Back-to-back row hits re-enter the same state, so restart on rollover too
        if (n_state != state || state_end)
            n_timing_count = 12'd1;
        else
            n_timing_count = timing_count + 12'd1;
    end

    always_comb begin
        case (state)
            dram_pack::LOAD_BG0_REG3: load_idx = 3'd1;
            dram_pack::LOAD_BG1_REG6: load_idx = 3'd2;
            dram_pack::LOAD_BG1_REG5: load_idx = 3'd3;
            dram_pack::LOAD_BG1_REG4: load_idx = 3'd4;
            dram_pack::LOAD_BG0_REG2: load_idx = 3'd5;
            dram_pack::LOAD_BG0_REG0: load_idx = 3'd6;
            default:                  load_idx = 3'd0;
        endcase
    end

    assign load_entry = dram_pack::INIT_TABLE[load_idx];

    // Pin encoding, one command cycle at the start of each state
    always_comb begin
        cmd     = dram_pack::DESEL_CMD;
        cke     = 1'b1;
        reset_n = 1'b1;
        bg      = '0;
        ba      = '0;
        addr    = '0;
        case (state)
            dram_pack::POWER_UP,
            dram_pack::PRE_RESET: begin
                cmd     = dram_pack::POWER_UP_PRG;
                cke     = 1'b0;
                reset_n = 1'b0;
            end
            dram_pack::RESET: cke = 1'b0; // RESET_n released, CKE still low
            dram_pack::NOP: ;
            dram_pack::LOAD_BG0_REG1,
            dram_pack::LOAD_BG0_REG3,
            dram_pack::LOAD_BG1_REG6,
            dram_pack::LOAD_BG1_REG5,
            dram_pack::LOAD_BG1_REG4,
            dram_pack::LOAD_BG0_REG2,
            dram_pack::LOAD_BG0_REG0: begin
                if (first_cycle) begin
                    cmd  = dram_pack::LOAD_MODE_CMD;
                    bg   = load_entry[17:16];
                    ba   = load_entry[15:14];
                    addr = load_entry[13:0];
                end
            end
            dram_pack::ZQ_CL: begin
                if (first_cycle) begin
                    cmd  = dram_pack::ZQ_CMD;
                    addr = 14'h0400; // A10 high selects ZQCL
                end
            end
            dram_pack::IDLE: cmd = dram_pack::NOP_CMD;
            dram_pack::ACTIVATE: begin
                if (first_cycle) begin
                    cmd  = {dram_pack::ACTIVATE_CMD[4:3], dr_sche.cur_row[16:14]};
                    bg   = dr_sche.cur_bg;
                    ba   = dr_sche.cur_ba;
                    addr = dr_sche.cur_row[13:0];
                end
            end
            dram_pack::WRITE_COMMAND,
            dram_pack::READ_COMMAND: begin
                if (first_cycle) begin
                    cmd  = (state == dram_pack::WRITE_COMMAND) ? dram_pack::WRITE_CMD
                                                               : dram_pack::READ_CMD;
                    bg   = dr_sche.cur_bg;
                    ba   = dr_sche.cur_ba;
                    // A12 high for full BL8, A10 low for no auto precharge
                    addr = {1'b0, 1'b1, 1'b0, 1'b0, dr_sche.cur_col};
                end
            end
            dram_pack::PRECHARGE: begin
                if (first_cycle) begin
                    cmd = dram_pack::PRECHARGE_CMD;
                    bg  = open_bg;
                    ba  = open_ba; // A10 low, single bank
                end
            end
            default: ;
        endcase
    end

    assign {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} = cmd;

    assign dr_sche.request_done = state_end && (state == dram_pack::READ_COMMAND
                                             || state == dram_pack::WRITE_COMMAND);
    assign done = dr_sche.request_done;

endmodule

// ==== common/dram_command_if.sv ====
`timescale 1ns/1ps

interface dram_command_if;

    // Request at the queue head
    logic              cur_valid;
    logic              cur_write;
    dram_pack::bg_t    cur_bg;
    dram_pack::ba_t    cur_ba;
    dram_pack::row_t   cur_row;
    dram_pack::col_t   cur_col;

    // Follow-through request, one behind the head
    logic              nxt_valid;
    logic              nxt_write;
    dram_pack::bg_t    nxt_bg;
    dram_pack::ba_t    nxt_ba;
    dram_pack::row_t   nxt_row;

    logic              request_done; // Pops the head entry

    modport sched (
        output cur_valid, cur_write, cur_bg, cur_ba, cur_row, cur_col,
        output nxt_valid, nxt_write, nxt_bg, nxt_ba, nxt_row,
        input  request_done
    );

    modport cmd (
        input  cur_valid, cur_write, cur_bg, cur_ba, cur_row, cur_col,
        input  nxt_valid, nxt_write, nxt_bg, nxt_ba, nxt_row,
        output request_done
    );

endinterface

// ==== common/dram_pack.sv ====
package dram_pack;

    // Host address layout, high bits down: row, bank group, bank, column
    typedef logic [26:0] host_addr_t;
    typedef logic [1:0]  bg_t;
    typedef logic [1:0]  ba_t;
    typedef logic [16:0] row_t;
    typedef logic [9:0]  col_t;

    // Field positions inside host_addr_t
    // The host row field is 13 bits wide and zero-extended to row_t
    localparam int BA_LSB  = 10;
    localparam int BG_LSB  = 12;
    localparam int ROW_LSB = 14;

    typedef enum logic [4:0] {
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        LOAD_BG0_REG1,
        LOAD_BG0_REG3,
        LOAD_BG1_REG6,
        LOAD_BG1_REG5,
        LOAD_BG1_REG4,
        LOAD_BG0_REG2,
        LOAD_BG0_REG0,
        ZQ_CL,
        IDLE,
        ACTIVATE,
        WRITE_COMMAND,
        READ_COMMAND,
        PRECHARGE
    } dram_state_t;

    // {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14}
    typedef logic [4:0] cmd_code_t;

    localparam cmd_code_t DESEL_CMD     = 5'b11111;
    localparam cmd_code_t NOP_CMD       = 5'b01111;
    localparam cmd_code_t LOAD_MODE_CMD = 5'b01000;
    localparam cmd_code_t ZQ_CMD        = 5'b01110;
    localparam cmd_code_t ACTIVATE_CMD  = 5'b00000; // Low three bits carry row[16:14]
    localparam cmd_code_t WRITE_CMD     = 5'b01100;
    localparam cmd_code_t READ_CMD      = 5'b01101;
    localparam cmd_code_t PRECHARGE_CMD = 5'b01010;
    localparam cmd_code_t POWER_UP_PRG  = 5'b10000; // Chip deselected while RESET_n is low

    // Mode register loads in issue order, each entry {bg, ba, addr[13:0]}
    localparam int INIT_LOADS = 7;
    localparam logic [17:0] INIT_TABLE [INIT_LOADS] = '{
        {2'd0, 2'd1, 14'h0001},  // MR1
        {2'd0, 2'd3, 14'h0000},  // MR3
        {2'd1, 2'd2, 14'h080F},  // MR6
        {2'd1, 2'd1, 14'h0000},  // MR5
        {2'd1, 2'd0, 14'h1000},  // MR4
        {2'd0, 2'd2, 14'h0088},  // MR2
        {2'd0, 2'd0, 14'h041D}   // MR0
    };

endpackage
